// ==== compile.f ====
hw/uart_pkg.sv
hw/uart_baud_gen.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_top.sv
sim/tb_uart.sv

// ==== hw/uart_baud_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_baud_gen #(
	parameter int OS_DIV = 2 // tx_clk cycles per os tick, at least one
) (
	input  logic i_tx_clk,
	input  logic i_reset_tx,
	output logic o_os_tick,  // one cycle every OS_DIV cycles
	output logic o_bit_tick  // same cycle as every OS_RATE-th os tick
);
	import uart_pkg::*;

	localparam int DIV_W = (OS_DIV > 1) ? $clog2(OS_DIV) : 1; // no zero width at OS_DIV 1

	logic [DIV_W-1:0]    div_cnt_q; // cycles since last os tick
	logic [OS_CNT_W-1:0] phase_q;   // os ticks since last bit tick
	logic                div_wrap;  // this cycle closes an os period

	assign div_wrap = (div_cnt_q == DIV_W'(OS_DIV - 1));

	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			div_cnt_q  <= '0;
			phase_q    <= '0;
			o_os_tick  <= 1'b0;
			o_bit_tick <= 1'b0;
		end else begin
			o_os_tick  <= div_wrap;                                     // first one OS_DIV after reset
			o_bit_tick <= div_wrap && (phase_q == OS_CNT_W'(OS_RATE - 1)); // rides on an os tick
			if (div_wrap) begin
				div_cnt_q <= '0;
				if (phase_q == OS_CNT_W'(OS_RATE - 1))
					phase_q <= '0;              // new bit period
				else
					phase_q <= phase_q + 1'b1;
			end else begin
				div_cnt_q <= div_cnt_q + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

	// frame layout, LSB first on the line
	localparam int DATA_WIDTH = 8;                  // data bits per frame
	localparam int FRAME_BITS = DATA_WIDTH + 3;     // start + data + parity + stop

	// receiver oversampling
	localparam int OS_RATE  = 8;                    // os ticks per bit
	localparam int OS_CNT_W = $clog2(OS_RATE);      // phase counter width

	// bit index has to reach FRAME_BITS itself
	localparam int BIT_CNT_W = $clog2(FRAME_BITS + 1);

	// field view of one frame, stop bit at the MSB
	typedef struct packed {
		logic                  stop;   // must be high
		logic                  parity; // even or odd over data
		logic [DATA_WIDTH-1:0] data;   // payload byte
		logic                  start;  // always low
	} uart_frame_s;

	// one frame word, flat for shifting and as fields for build and check
	typedef union packed {
		logic [FRAME_BITS-1:0] vec;    // bit 0 goes out first
		uart_frame_s           fields;
	} uart_frame_u;

endpackage

`default_nettype wire

// ==== hw/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
	parameter bit PARITY_ODD = 1'b0 // 0 even, 1 odd
) (
	input  logic                           i_tx_clk,
	input  logic                           i_reset_tx,
	input  logic                           i_os_tick,  // OS_RATE pulses per bit
	input  logic                           i_serial,   // asynchronous line
	output logic [uart_pkg::DATA_WIDTH-1:0] o_rx_data,  // held until next frame
	output logic                           o_rx_valid, // one cycle per frame
	output logic                           o_rx_error  // parity or stop fault, with valid
);
	import uart_pkg::*;

	logic [2:0]           sync_q;     // line synchronizer, bit 2 is the safe copy
	logic                 line;       // synchronized line
	logic                 line_prev_q; // line one cycle earlier
	logic                 fall;       // high to low on the synchronized line
	logic                 active_q;   // frame in progress
	logic [OS_CNT_W-1:0]  os_cnt_q;   // os ticks since last sample point
	logic [BIT_CNT_W-1:0] bit_cnt_q;  // samples taken, start included
	logic                 start_pt;   // half a bit after the edge
	logic                 sample_pt;  // whole bit after previous sample
	logic                 last_bit;   // this sample is the stop bit
	logic                 parity_exp; // parity recomputed from received data
	uart_frame_u          frame_q;    // samples so far, newest at the MSB
	uart_frame_u          frame_d;    // frame including this cycle's sample

	assign line      = sync_q[2];
	assign fall      = line_prev_q && !line;
	assign start_pt  = active_q && i_os_tick && (bit_cnt_q == '0)
	                   && (os_cnt_q == OS_CNT_W'(OS_RATE / 2 - 1)); // fourth os tick
	assign sample_pt = active_q && i_os_tick && (bit_cnt_q != '0)
	                   && (os_cnt_q == OS_CNT_W'(OS_RATE - 1));     // eighth os tick
	assign last_bit  = (bit_cnt_q == BIT_CNT_W'(FRAME_BITS - 1));

	always_comb begin
		frame_d.vec = {line, frame_q.vec[FRAME_BITS-1:1]}; // shift in from the top
		parity_exp  = (^frame_d.fields.data) ^ PARITY_ODD;
	end

	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			sync_q      <= 3'b111; // line reads idle out of reset
			line_prev_q <= 1'b1;
			active_q    <= 1'b0;
			os_cnt_q    <= '0;
			bit_cnt_q   <= '0;
			o_rx_valid  <= 1'b0;
			o_rx_error  <= 1'b0;
		end else begin
			sync_q      <= {sync_q[1:0], i_serial};
			line_prev_q <= line;
			o_rx_valid  <= 1'b0; // pulses only
			o_rx_error  <= 1'b0;
			if (!active_q) begin
				if (fall) begin
					active_q <= 1'b1; // edge only, a low stop bit does not retrigger
					os_cnt_q <= '0;
				end
			end else if (start_pt) begin
				os_cnt_q <= '0; // realign to mid start bit
				if (line)
					active_q <= 1'b0; // glitch, back to idle silently
				else
					bit_cnt_q <= bit_cnt_q + 1'b1;
			end else if (sample_pt) begin
				os_cnt_q <= '0;
				if (last_bit) begin
					active_q   <= 1'b0;
					bit_cnt_q  <= '0;
					o_rx_valid <= 1'b1;
					o_rx_error <= (frame_d.fields.parity != parity_exp) || !frame_d.fields.stop;
				end else begin
					bit_cnt_q <= bit_cnt_q + 1'b1;
				end
			end else if (i_os_tick) begin
				os_cnt_q <= os_cnt_q + 1'b1;
			end
		end
	end

	// sample shift register and received byte
	always_ff @(posedge i_tx_clk) begin
		if ((start_pt && !line) || sample_pt)
			frame_q <= frame_d; // start bit lands at bit 0 after the last shift
		if (sample_pt && last_bit)
			o_rx_data <= frame_d.fields.data;
	end

endmodule

`default_nettype wire

// ==== hw/uart_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_top #(
	parameter bit PARITY_ODD = 1'b0, // 0 even, 1 odd, both sides
	parameter int OS_DIV     = 2     // tx_clk cycles per os tick
) (
	input  logic                           tx_clk,
	input  logic                           reset_tx,   // synchronous, active high
	input  logic                           i_enable,   // send strobe
	input  logic [uart_pkg::DATA_WIDTH-1:0] i_data,     // byte to send
	input  logic                           i_serial,   // receive line
	output logic                           o_busy,     // transmitter occupied
	output logic                           o_serial,   // transmit line
	output logic [uart_pkg::DATA_WIDTH-1:0] o_rx_data,  // last received byte
	output logic                           o_rx_valid, // frame received
	output logic                           o_rx_error  // frame had a fault
);

	logic os_tick;  // oversample tick to receiver
	logic bit_tick; // bit tick to transmitter

	uart_baud_gen #(
		.OS_DIV(OS_DIV)
	) u_baud_gen (
		.i_tx_clk  (tx_clk),
		.i_reset_tx(reset_tx),
		.o_os_tick (os_tick),
		.o_bit_tick(bit_tick)
	);

	uart_tx #(
		.PARITY_ODD(PARITY_ODD)
	) u_tx (
		.i_tx_clk  (tx_clk),
		.i_reset_tx(reset_tx),
		.i_bit_tick(bit_tick),
		.i_enable  (i_enable),
		.i_data    (i_data),
		.o_busy    (o_busy),
		.o_serial  (o_serial)
	);

	uart_rx #(
		.PARITY_ODD(PARITY_ODD)
	) u_rx (
		.i_tx_clk  (tx_clk),
		.i_reset_tx(reset_tx),
		.i_os_tick (os_tick),
		.i_serial  (i_serial),
		.o_rx_data (o_rx_data),
		.o_rx_valid(o_rx_valid),
		.o_rx_error(o_rx_error)
	);

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
	parameter bit PARITY_ODD = 1'b0 // 0 even, 1 odd
) (
	input  logic                           i_tx_clk,
	input  logic                           i_reset_tx,
	input  logic                           i_bit_tick, // one pulse per bit period
	input  logic                           i_enable,   // request strobe, honoured when idle
	input  logic [uart_pkg::DATA_WIDTH-1:0] i_data,     // captured with an accepted enable
	output logic                           o_busy,     // high until the stop bit ends
	output logic                           o_serial    // line, idles high
);
	import uart_pkg::*;

	uart_frame_u          frame_q;    // remaining frame bits, next one at bit 0
	logic                 pending_q;  // loaded, start bit waits for a bit tick
	logic [BIT_CNT_W-1:0] bit_cnt_q;  // bits already driven on the line
	logic                 accept;     // enable taken this cycle
	logic                 frame_done; // stop bit has run its full period
	logic                 shift_en;   // drive next frame bit

	assign o_busy     = pending_q || (bit_cnt_q != '0);
	assign accept     = i_enable && !o_busy;                       // ignored while busy
	assign frame_done = i_bit_tick && (bit_cnt_q == BIT_CNT_W'(FRAME_BITS));
	assign shift_en   = i_bit_tick && o_busy && !frame_done;

	// control and line
	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			pending_q <= 1'b0;
			bit_cnt_q <= '0;
			o_serial  <= 1'b1; // idle level
		end else begin
			if (accept)
				pending_q <= 1'b1; // busy shows next cycle
			if (shift_en) begin
				pending_q <= 1'b0;
				bit_cnt_q <= bit_cnt_q + 1'b1;
				o_serial  <= frame_q.vec[0]; // start bit on the first tick
			end else if (frame_done) begin
				bit_cnt_q <= '0;   // busy drops with this
				o_serial  <= 1'b1;
			end
		end
	end

	// frame register, built through the fields and emptied through the vector
	always_ff @(posedge i_tx_clk) begin
		if (accept) begin
			frame_q.fields.start  <= 1'b0;
			frame_q.fields.data   <= i_data;
			frame_q.fields.parity <= (^i_data) ^ PARITY_ODD; // odd flips the even bit
			frame_q.fields.stop   <= 1'b1;
		end else if (shift_en) begin
			frame_q.vec <= {1'b1, frame_q.vec[FRAME_BITS-1:1]}; // LSB first, fill with idle
		end
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the UART testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_uart \
	--Mdir obj_dir -o tb_uart_sim \
	-f compile.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/tb_uart_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "All tests passed!"; then
	exit 0
fi
echo "pass message not found"
exit 1

// ==== sim/tb_uart.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_uart;
	import uart_pkg::*;

	localparam bit PARITY_ODD  = 1'b0;
	localparam int OS_DIV      = 2;
	localparam int BIT_CYC     = OS_DIV * OS_RATE;          // 16 cycles per bit
	localparam int FRAME_CYC   = FRAME_BITS * BIT_CYC;      // 176 cycles per frame
	localparam int MAX_FRAMES  = 40;                        // 27 frames sent, plus idle gaps
	localparam int TIMEOUT_CYC = MAX_FRAMES * FRAME_CYC + 960; // 8000 cycles

	logic                  tx_clk;
	logic                  reset_tx;
	logic                  tx_enable;
	logic [DATA_WIDTH-1:0] tx_data;
	logic                  tx_busy;
	logic                  tx_line;   // DUT transmit line
	logic                  rx_line;   // DUT receive line
	logic [DATA_WIDTH-1:0] rx_data;
	logic                  rx_valid;
	logic                  rx_error;
	logic                  line_sel;  // 0 loopback, 1 bit-banger
	logic                  bang_line; // injected level

	logic [DATA_WIDTH:0]   exp_q[$];  // {error, data} per expected frame
	logic [DATA_WIDTH:0]   exp_entry;
	string                 cur_test;
	int                    exp_total; // frames expected so far
	int                    rx_count;  // frames seen so far
	int                    cmp_errors;
	int                    seq_errors;
	int                    cycles;
	int                    tests_run;
	int                    tests_failed;
	int                    test_base;
	int                    seed_val;
	int                    k;
	logic [DATA_WIDTH-1:0] rnd_byte;
	logic [FRAME_BITS-1:0] bad_frame;
	logic [DATA_WIDTH-1:0] fixed_bytes [4] = '{8'h00, 8'hFF, 8'hA5, 8'h5A};

	assign rx_line = line_sel ? bang_line : tx_line; // loopback or injection

	uart_top #(
		.PARITY_ODD(PARITY_ODD),
		.OS_DIV    (OS_DIV)
	) u_uart_top (
		.tx_clk    (tx_clk),
		.reset_tx  (reset_tx),
		.i_enable  (tx_enable),
		.i_data    (tx_data),
		.i_serial  (rx_line),
		.o_busy    (tx_busy),
		.o_serial  (tx_line),
		.o_rx_data (rx_data),
		.o_rx_valid(rx_valid),
		.o_rx_error(rx_error)
	);

	always #10 tx_clk = ~tx_clk; // 20 ns period

	// start, data LSB first, parity, stop
	function automatic logic [FRAME_BITS-1:0] ref_frame(input logic [DATA_WIDTH-1:0] b);
		int   ones;
		int   i;
		logic par;
		ones = 0;
		for (i = 0; i < DATA_WIDTH; i++) begin
			if (b[i])
				ones++;
		end
		if (PARITY_ODD)
			par = ((ones % 2) == 0); // ones count odd with the parity bit
		else
			par = ((ones % 2) == 1); // ones count even with the parity bit
		return {1'b1, par, b, 1'b0};
	endfunction

	// compare each received frame with the oldest expected one
	always @(posedge tx_clk) begin
		if (!reset_tx && rx_valid) begin
			rx_count <= rx_count + 1;
			if (exp_q.size() == 0) begin
				$display("unexpected frame in test %s with data %h", cur_test, rx_data);
				cmp_errors++;
			end else begin
				exp_entry = exp_q.pop_front();
				assert (rx_data == exp_entry[DATA_WIDTH-1:0]) else begin
					$display("Error %s: rx data expected %h, actual %h", cur_test,
						exp_entry[DATA_WIDTH-1:0], rx_data);
					cmp_errors++;
				end
				assert (rx_error == exp_entry[DATA_WIDTH]) else begin
					$display("Error %s: rx error expected %b, actual %b", cur_test,
						exp_entry[DATA_WIDTH], rx_error);
					cmp_errors++;
				end
			end
		end
	end

	always @(posedge tx_clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYC) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYC);
			$display("Test failures found");
			$finish;
		end
	end

	task automatic begin_test(input string name);
		cur_test  = name;
		test_base = seq_errors + cmp_errors;
	endtask

	task automatic end_test();
		@(negedge tx_clk); // counters settled
		tests_run++;
		if (seq_errors + cmp_errors != test_base) begin
			tests_failed++;
			$display("test %s: FAIL", cur_test);
		end else begin
			$display("test %s: ok", cur_test);
		end
	endtask

	// strobe one byte, optionally strobe a second one while busy, then watch o_busy
	task automatic send_byte(input logic [DATA_WIDTH-1:0] b, input bit again,
		input logic [DATA_WIDTH-1:0] b2);
		int busy_len;
		busy_len = 0;
		@(posedge tx_clk);
		tx_enable <= 1'b1;
		tx_data   <= b;
		exp_q.push_back({1'b0, b});
		exp_total++;
		@(posedge tx_clk); // DUT takes the strobe here
		tx_enable <= 1'b0;
		@(posedge tx_clk);
		assert (tx_busy) else begin
			$display("Error %s: o_busy after enable expected 1, actual %b", cur_test, tx_busy);
			seq_errors++;
		end
		while (tx_busy && busy_len < 2 * FRAME_CYC) begin
			busy_len++;
			if (again && busy_len == 5) begin
				tx_enable <= 1'b1; // lands while busy
				tx_data   <= b2;
			end else begin
				tx_enable <= 1'b0;
			end
			@(posedge tx_clk);
		end
		// up to one bit of wait for the start, then the whole frame
		assert (busy_len >= FRAME_CYC + 1 && busy_len <= FRAME_CYC + BIT_CYC) else begin
			$display("Error %s: o_busy cycles expected %0d to %0d, actual %0d", cur_test,
				FRAME_CYC + 1, FRAME_CYC + BIT_CYC, busy_len);
			seq_errors++;
		end
	endtask

	task automatic wait_rx(input int target);
		int waited;
		waited = 0;
		while (rx_count < target && waited < 2 * FRAME_CYC) begin
			@(posedge tx_clk);
			waited++;
		end
		assert (rx_count >= target) else begin
			$display("no frame arrived in test %s within %0d cycles", cur_test, waited);
			seq_errors++;
		end
	endtask

	// bit-bang one frame onto the receive line
	task automatic inject_frame(input logic [FRAME_BITS-1:0] f, input logic err);
		int i;
		exp_q.push_back({err, f[DATA_WIDTH:1]});
		exp_total++;
		@(posedge tx_clk);
		line_sel <= 1'b1;
		for (i = 0; i < FRAME_BITS; i++) begin
			bang_line <= f[i];
			repeat (BIT_CYC) @(posedge tx_clk);
		end
		bang_line <= 1'b1;
		repeat (2 * BIT_CYC) @(posedge tx_clk);
		line_sel <= 1'b0; // back to loopback, tx idles high
		wait_rx(exp_total);
	endtask

	initial begin
		tx_clk     = 1'b0;
		reset_tx   = 1'b1;
		tx_enable  = 1'b0;
		tx_data    = '0;
		line_sel   = 1'b0;
		bang_line  = 1'b1;
		exp_total  = 0;
		rx_count   = 0;
		cmp_errors = 0;
		seq_errors = 0;
		cycles     = 0;
		tests_run  = 0;
		tests_failed = 0;
		seed_val   = $urandom(4);
		repeat (3) @(posedge tx_clk);
		reset_tx <= 1'b0;
		@(posedge tx_clk);

		begin_test("reset_idle");
		assert (tx_line == 1'b1 && !tx_busy) else begin
			$display("Error %s: serial/busy expected 1/0, actual %b/%b", cur_test, tx_line, tx_busy);
			seq_errors++;
		end
		repeat (20) begin
			@(posedge tx_clk);
			assert (!rx_valid && !rx_error) else begin
				$display("Error %s: rx valid/error expected 0/0, actual %b/%b", cur_test,
					rx_valid, rx_error);
				seq_errors++;
			end
		end
		end_test();

		begin_test("loopback_fixed");
		for (k = 0; k < 4; k++) begin
			send_byte(fixed_bytes[k], 1'b0, '0);
			wait_rx(exp_total);
		end
		end_test();

		begin_test("loopback_random");
		for (k = 0; k < 20; k++) begin
			rnd_byte = 8'($urandom());
			send_byte(rnd_byte, 1'b0, '0);
			wait_rx(exp_total);
		end
		end_test();

		begin_test("enable_while_busy");
		send_byte(8'h3C, 1'b1, 8'hC3); // second strobe must be dropped
		wait_rx(exp_total);
		repeat (2 * BIT_CYC) @(posedge tx_clk);
		assert (!tx_busy && rx_count == exp_total) else begin
			$display("Error %s: frames expected %0d, actual %0d", cur_test, exp_total, rx_count);
			seq_errors++;
		end
		end_test();

		begin_test("bad_parity");
		bad_frame = ref_frame(8'h96);
		bad_frame[FRAME_BITS-2] = ~bad_frame[FRAME_BITS-2]; // flip parity
		inject_frame(bad_frame, 1'b1);
		end_test();

		begin_test("bad_stop");
		bad_frame = ref_frame(8'h4B);
		bad_frame[FRAME_BITS-1] = 1'b0; // stop bit low
		inject_frame(bad_frame, 1'b1);
		end_test();

		begin_test("start_glitch");
		@(posedge tx_clk);
		line_sel  <= 1'b1;
		bang_line <= 1'b0;
		@(posedge tx_clk);
		bang_line <= 1'b1; // one cycle low only
		repeat (FRAME_CYC + 2 * BIT_CYC) @(posedge tx_clk); // longer than a false frame
		assert (rx_count == exp_total) else begin
			$display("Error %s: frames expected %0d, actual %0d", cur_test, exp_total, rx_count);
			seq_errors++;
		end
		line_sel <= 1'b0;
		end_test();

		assert (exp_q.size() == 0) else begin
			$display("%0d expected frames never arrived", exp_q.size());
			seq_errors++;
		end
		$display("tests run %0d, tests failed %0d, check errors %0d", tests_run, tests_failed,
			seq_errors + cmp_errors);
		if (tests_failed == 0 && seq_errors + cmp_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire
